// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_l2_axi_bridge
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) common/l2_axi_settings.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

check: run

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/l2_axi_pkg.sv
hw/l2_axi_read_channel.sv
hw/l2_axi_write_channel.sv
hw/axi_error_tracker.sv
hw/l2_axi_bridge.sv
testbench/tb_axi_mem_model.sv
testbench/tb_l2_axi_bridge.sv

// ==== common/l2_axi_pkg.sv ====
/* request, beat, AXI channel and status structs for the L2 to AXI bridge,
   plus the AXI response code constants */

`include "l2_axi_settings.svh"

package l2_axi_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // same request layout for reads and writes
    typedef struct packed {
        logic [`L2_AXI_ADDR_W-1:0] addr;
        logic [7:0]                len;  // beats - 1
        logic [2:0]                size;
    } l2_req_t;

    typedef struct packed {
        logic [`L2_AXI_DATA_W-1:0] data;
        logic                      last;
    } l2_rd_beat_t;

    typedef struct packed {
        logic [`L2_AXI_DATA_W-1:0]   data;
        logic [`L2_AXI_DATA_W/8-1:0] strb;
        logic                        last;
    } l2_wr_beat_t;

    // AR and AW
    typedef struct packed {
        logic [`L2_AXI_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic [3:0]                id;
    } axi_ax_t;

    typedef struct packed {
        logic [`L2_AXI_DATA_W-1:0] data;
        logic [1:0]                resp;
        logic                      last;
    } axi_r_t;

    typedef struct packed {
        logic [`L2_AXI_DATA_W-1:0]   data;
        logic [`L2_AXI_DATA_W/8-1:0] strb;
        logic                        last;
        logic [3:0]                  id;  // AXI3 wid
    } axi_w_t;

    // one-cycle response report to the tracker
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } resp_evt_t;

    typedef struct packed {
        logic                         rd_err;
        logic                         wr_err;
        logic [`L2_AXI_ERR_CNT_W-1:0] rd_err_cnt;
        logic [`L2_AXI_ERR_CNT_W-1:0] wr_err_cnt;
    } err_status_t;

endpackage

// ==== common/l2_axi_settings.svh ====
/* bus widths, fixed AXI ids, burst code, DECERR data pattern and error counter width */

`ifndef L2_AXI_SETTINGS_SVH
`define L2_AXI_SETTINGS_SVH

// address and data bus widths
`define L2_AXI_ADDR_W 32
`define L2_AXI_DATA_W 32

// ids are fixed per channel, one transaction each
`define L2_AXI_RD_ID 4'd0
`define L2_AXI_WR_ID 4'd1

`define L2_AXI_BURST_INCR 2'b01

// pattern handed to the L2 in place of data on a DECERR beat
`define L2_AXI_ERR_DATA 32'habcd1234

`define L2_AXI_ERR_CNT_W 8

`endif

// ==== hw/axi_error_tracker.sv ====
/* sticky error flags and saturating error counters for the read and write channels */

`timescale 1ns/1ps

module axi_error_tracker (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      err_clear,
    input  l2_axi_pkg::resp_evt_t     rd_evt,
    input  l2_axi_pkg::resp_evt_t     wr_evt,
    output l2_axi_pkg::err_status_t   err_status
);

    l2_axi_pkg::err_status_t status_q;
    logic                    rd_hit;
    logic                    wr_hit;

    function automatic logic is_err(input l2_axi_pkg::resp_evt_t evt);
        return evt.valid && (evt.resp == l2_axi_pkg::RESP_SLVERR ||
                             evt.resp == l2_axi_pkg::RESP_DECERR);
    endfunction

    assign rd_hit = is_err(rd_evt);
    assign wr_hit = is_err(wr_evt);

    always_ff @(posedge clk) begin
        if (!rstn || err_clear) begin
            status_q <= '0;
        end else begin
            if (rd_hit) begin
                status_q.rd_err <= 1'b1;
                if (status_q.rd_err_cnt != '1) begin  // saturate
                    status_q.rd_err_cnt <= status_q.rd_err_cnt + 1'b1;
                end
            end
            if (wr_hit) begin
                status_q.wr_err <= 1'b1;
                if (status_q.wr_err_cnt != '1) begin
                    status_q.wr_err_cnt <= status_q.wr_err_cnt + 1'b1;
                end
            end
        end
    end

    assign err_status = status_q;

    // counts only go down through err_clear
    a_cnt_monotonic: assert property (
        @(posedge clk) disable iff (!rstn)
        !err_clear |=> err_status.rd_err_cnt >= $past(err_status.rd_err_cnt) &&
                       err_status.wr_err_cnt >= $past(err_status.wr_err_cnt)
    );

endmodule

// ==== hw/l2_axi_bridge.sv ====
/* top level of the L2 to AXI3 bridge, read and write channels plus error tracker */

`timescale 1ns/1ps

module l2_axi_bridge (
    input  logic                     clk,
    input  logic                     rstn,
    // L2 read
    input  logic                     rd_req,
    input  l2_axi_pkg::l2_req_t      rd_req_info,
    output logic                     rd_addr_ok,
    output logic                     rd_data_ok,
    output l2_axi_pkg::l2_rd_beat_t  rd_beat,
    // L2 write
    input  logic                     wr_req,
    input  l2_axi_pkg::l2_req_t      wr_req_info,
    output logic                     wr_addr_ok,
    input  logic                     wr_beat_valid,
    input  l2_axi_pkg::l2_wr_beat_t  wr_beat,
    output logic                     wr_data_ok,
    output logic                     wr_resp_valid,
    output logic [1:0]               wr_resp,
    input  logic                     wr_resp_ready,
    // AXI read
    output l2_axi_pkg::axi_ax_t      ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  l2_axi_pkg::axi_r_t       r,
    input  logic                     rvalid,
    output logic                     rready,
    // AXI write
    output l2_axi_pkg::axi_ax_t      aw,
    output logic                     awvalid,
    input  logic                     awready,
    output l2_axi_pkg::axi_w_t       w,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready,
    // status
    input  logic                     err_clear,
    output l2_axi_pkg::err_status_t  err_status
);

    l2_axi_pkg::resp_evt_t rd_evt;
    l2_axi_pkg::resp_evt_t wr_evt;

    l2_axi_read_channel i_rd_chan (
        .clk         (clk),
        .rstn        (rstn),
        .rd_req      (rd_req),
        .rd_req_info (rd_req_info),
        .rd_addr_ok  (rd_addr_ok),
        .rd_data_ok  (rd_data_ok),
        .rd_beat     (rd_beat),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .rd_evt      (rd_evt)
    );

    l2_axi_write_channel i_wr_chan (
        .clk           (clk),
        .rstn          (rstn),
        .wr_req        (wr_req),
        .wr_req_info   (wr_req_info),
        .wr_addr_ok    (wr_addr_ok),
        .wr_beat_valid (wr_beat_valid),
        .wr_beat       (wr_beat),
        .wr_data_ok    (wr_data_ok),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp       (wr_resp),
        .wr_resp_ready (wr_resp_ready),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .wr_evt        (wr_evt)
    );

    axi_error_tracker i_err_trk (
        .clk        (clk),
        .rstn       (rstn),
        .err_clear  (err_clear),
        .rd_evt     (rd_evt),
        .wr_evt     (wr_evt),
        .err_status (err_status)
    );

endmodule

// ==== hw/l2_axi_read_channel.sv ====
/* read channel, one L2 read request becomes one INCR burst on AR/R,
   returned beats go back to the L2 as strobes */

`timescale 1ns/1ps
`include "l2_axi_settings.svh"

module l2_axi_read_channel (
    input  logic                     clk,
    input  logic                     rstn,
    // L2 side
    input  logic                     rd_req,
    input  l2_axi_pkg::l2_req_t      rd_req_info,
    output logic                     rd_addr_ok,
    output logic                     rd_data_ok,
    output l2_axi_pkg::l2_rd_beat_t  rd_beat,
    // AXI side
    output l2_axi_pkg::axi_ax_t      ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  l2_axi_pkg::axi_r_t       r,
    input  logic                     rvalid,
    output logic                     rready,
    // to error tracker
    output l2_axi_pkg::resp_evt_t    rd_evt
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t              state;
    state_t              state_nxt;
    l2_axi_pkg::l2_req_t req_q;
    logic                ar_hs;
    logic                r_hs;

    assign arvalid = (state == ST_ADDR);
    assign rready  = (state == ST_DATA);
    assign ar_hs   = arvalid && arready;
    assign r_hs    = rvalid && rready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (rd_req) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (ar_hs) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (r_hs && r.last) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // request only loads in idle, so ar holds through any arready stall
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && rd_req) begin
            req_q <= rd_req_info;
        end
    end

    always_comb begin
        ar.addr  = req_q.addr;
        ar.len   = req_q.len;
        ar.size  = req_q.size;  // no narrow alignment
        ar.burst = `L2_AXI_BURST_INCR;
        ar.id    = `L2_AXI_RD_ID;
    end

    assign rd_addr_ok = ar_hs;
    assign rd_data_ok = r_hs;  // L2 takes every beat, no stall

    always_comb begin
        rd_beat.data = r.data;
        if (r.resp == l2_axi_pkg::RESP_DECERR) begin
            rd_beat.data = `L2_AXI_ERR_DATA;
        end
        rd_beat.last = r.last;
    end

    assign rd_evt.valid = r_hs;
    assign rd_evt.resp  = r.resp;

    // AR payload may not move while waiting for arready
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

    // slave returns beats only once AR has been accepted
    a_no_early_rvalid: assert property (
        @(posedge clk) disable iff (!rstn)
        state != ST_DATA |-> !rvalid
    );

endmodule

// ==== hw/l2_axi_write_channel.sv ====
/* write channel, L2 write request becomes an AW transfer, a W burst fed
   by the L2 beat by beat and a B response handed back to the L2 */

`timescale 1ns/1ps
`include "l2_axi_settings.svh"

module l2_axi_write_channel (
    input  logic                     clk,
    input  logic                     rstn,
    // L2 side
    input  logic                     wr_req,
    input  l2_axi_pkg::l2_req_t      wr_req_info,
    output logic                     wr_addr_ok,
    input  logic                     wr_beat_valid,
    input  l2_axi_pkg::l2_wr_beat_t  wr_beat,
    output logic                     wr_data_ok,
    output logic                     wr_resp_valid,
    output logic [1:0]               wr_resp,
    input  logic                     wr_resp_ready,
    // AXI side
    output l2_axi_pkg::axi_ax_t      aw,
    output logic                     awvalid,
    input  logic                     awready,
    output l2_axi_pkg::axi_w_t       w,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready,
    // to error tracker
    output l2_axi_pkg::resp_evt_t    wr_evt
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t              state;
    state_t              state_nxt;
    l2_axi_pkg::l2_req_t req_q;
    logic                aw_hs;
    logic                w_hs;
    logic                b_hs;

    assign awvalid = (state == ST_ADDR);
    assign wvalid  = (state == ST_DATA) && wr_beat_valid;
    assign bready  = (state == ST_RESP) && wr_resp_ready;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (wr_req) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (aw_hs) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (w_hs && wr_beat.last) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (b_hs) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && wr_req) begin
            req_q <= wr_req_info;
        end
    end

    always_comb begin
        aw.addr  = req_q.addr;
        aw.len   = req_q.len;
        aw.size  = req_q.size;
        aw.burst = `L2_AXI_BURST_INCR;
        aw.id    = `L2_AXI_WR_ID;
    end

    // W payload comes straight from the L2 beat, held by the L2 until wr_data_ok
    always_comb begin
        w.data = wr_beat.data;
        w.strb = wr_beat.strb;
        w.last = wr_beat.last;
        w.id   = `L2_AXI_WR_ID;
    end

    assign wr_addr_ok    = aw_hs;
    assign wr_data_ok    = w_hs;
    assign wr_resp_valid = (state == ST_RESP) && bvalid;
    assign wr_resp       = bresp;

    assign wr_evt.valid = b_hs;
    assign wr_evt.resp  = bresp;

    // L2 keeps the beat steady while the slave stalls wready
    a_w_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(w)
    );

endmodule

// ==== testbench/tb_axi_mem_model.sv ====
/* AXI3 slave memory for the bridge testbench, random ready/valid stalls,
   DECERR above bit 20 and SLVERR above bit 21 */

`timescale 1ns/1ps

module tb_axi_mem_model (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [3:0]              stall,  // arready, rvalid, awready, wready enables
    input  l2_axi_pkg::axi_ax_t     ar,
    input  logic                    arvalid,
    output logic                    arready,
    output l2_axi_pkg::axi_r_t      r,
    output logic                    rvalid,
    input  logic                    rready,
    input  l2_axi_pkg::axi_ax_t     aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  l2_axi_pkg::axi_w_t      w,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready
);

    logic [31:0] mem [0:255];
    logic        rd_busy;
    logic        rv_hold;  // keeps rvalid up once shown
    logic [7:0]  rd_idx;
    logic [7:0]  rd_left;
    logic [1:0]  rd_resp_q;
    logic        wr_busy;
    logic        b_pend;
    logic [7:0]  wr_idx;
    logic [1:0]  wr_resp_q;

    function automatic logic [1:0] region_resp(input logic [31:0] addr);
        if (addr[20]) begin
            return l2_axi_pkg::RESP_DECERR;
        end
        if (addr[21]) begin
            return l2_axi_pkg::RESP_SLVERR;
        end
        return l2_axi_pkg::RESP_OKAY;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ i;
        end
    end

    assign arready = rstn && !rd_busy && stall[0];
    assign rvalid  = rd_busy && (rv_hold || stall[1]);
    assign awready = rstn && !wr_busy && stall[2];
    assign wready  = wr_busy && !b_pend && stall[3];
    assign bvalid  = b_pend;
    assign bresp   = wr_resp_q;

    always_comb begin
        r.data = mem[rd_idx];
        r.resp = rd_resp_q;
        r.last = (rd_left == 8'd0);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_busy <= 1'b0;
            rv_hold <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            rv_hold <= rvalid && !rready;
            if (arvalid && arready) begin
                rd_busy   <= 1'b1;
                rd_idx    <= ar.addr[9:2];
                rd_left   <= ar.len;
                rd_resp_q <= region_resp(ar.addr);
            end else if (rvalid && rready) begin
                rd_idx  <= rd_idx + 8'd1;
                rd_left <= rd_left - 8'd1;
                if (rd_left == 8'd0) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_busy   <= 1'b1;
                wr_idx    <= aw.addr[9:2];
                wr_resp_q <= region_resp(aw.addr);
            end
            if (wvalid && wready) begin
                wr_idx <= wr_idx + 8'd1;
                if (w.last) begin
                    b_pend <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                b_pend  <= 1'b0;
                wr_busy <= 1'b0;
            end
        end
    end

    // erroring bursts leave memory alone
    always @(posedge clk) begin
        if (rstn && wvalid && wready && wr_resp_q == l2_axi_pkg::RESP_OKAY) begin
            for (int b = 0; b < 4; b++) begin
                if (w.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= w.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== testbench/tb_l2_axi_bridge.sv ====
/* testbench for the L2 to AXI3 bridge, LFSR stimulus against a shadow memory
   and expected error counts */

`timescale 1ns/1ps
`include "l2_axi_settings.svh"

module tb_l2_axi_bridge;

    localparam int          TIMEOUT = 500;
    localparam logic [31:0] SEED    = 32'hd88f_0544;

    logic                    clk;
    logic                    rstn;
    logic                    rd_req;
    l2_axi_pkg::l2_req_t     rd_req_info;
    logic                    rd_addr_ok;
    logic                    rd_data_ok;
    l2_axi_pkg::l2_rd_beat_t rd_beat;
    logic                    wr_req;
    l2_axi_pkg::l2_req_t     wr_req_info;
    logic                    wr_addr_ok;
    logic                    wr_beat_valid;
    l2_axi_pkg::l2_wr_beat_t wr_beat;
    logic                    wr_data_ok;
    logic                    wr_resp_valid;
    logic [1:0]              wr_resp;
    logic                    wr_resp_ready;
    l2_axi_pkg::axi_ax_t     ar;
    logic                    arvalid;
    logic                    arready;
    l2_axi_pkg::axi_r_t      r;
    logic                    rvalid;
    logic                    rready;
    l2_axi_pkg::axi_ax_t     aw;
    logic                    awvalid;
    logic                    awready;
    l2_axi_pkg::axi_w_t      w;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic                    err_clear;
    l2_axi_pkg::err_status_t err_status;
    logic [3:0]              stall;

    logic [31:0] lfsr;
    logic [31:0] stall_lfsr;
    logic [31:0] shadow [0:255];
    int          errors;
    int          exp_rd_err;
    int          exp_wr_err;
    logic [31:0] v;
    logic [4:0]  rd_blk [0:5];
    logic [7:0]  rd_len [0:5];
    logic [4:0]  wr_blk [0:5];
    logic [7:0]  wr_len [0:5];

    l2_axi_bridge i_dut (.*);
    tb_axi_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // AXI stalls come from their own LFSR state
    always @(posedge clk) begin
        #2;
        for (int i = 0; i < 4; i++) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            stall[i]   = stall_lfsr[0];
        end
    end

    function automatic logic [31:0] make_addr(input logic [1:0] region, input logic [4:0] blk);
        return {10'd0, region, 10'd0, blk, 5'd0};  // 8-word aligned block
    endfunction

    function automatic logic [1:0] expected_resp(input logic [1:0] region);
        if (region[0]) begin
            return l2_axi_pkg::RESP_DECERR;
        end
        return region[1] ? l2_axi_pkg::RESP_SLVERR : l2_axi_pkg::RESP_OKAY;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic do_read(input logic [1:0] region, input logic [4:0] blk, input logic [7:0] len);
        logic [31:0] addr;
        logic [31:0] expd;
        logic [1:0]  resp;
        logic [7:0]  idx;
        int          n;
        int          t;
        addr = make_addr(region, blk);
        resp = expected_resp(region);
        rd_req = 1'b1;
        rd_req_info.addr = addr;
        rd_req_info.len  = len;
        rd_req_info.size = 3'd2;
        t = 0;
        @(posedge clk);
        while (!rd_addr_ok) begin
            if (t == TIMEOUT) abort_on_timeout("rd_addr_ok");
            t++;
            @(posedge clk);
        end
        if (ar.addr != addr || ar.len != len || ar.size != 3'd2 ||
            ar.burst != `L2_AXI_BURST_INCR || ar.id != `L2_AXI_RD_ID) begin
            $display("CHECK FAILED at %0t: AR %h for read of %h len %0d", $time, ar, addr, len);
            errors++;
        end
        #2 rd_req = 1'b0;
        n = 0;
        t = 0;
        while (n <= int'(len)) begin
            @(posedge clk);
            if (rd_data_ok) begin
                idx  = addr[9:2] + 8'(n);
                expd = (resp == l2_axi_pkg::RESP_DECERR) ? `L2_AXI_ERR_DATA : shadow[idx];
                if (rd_beat.data != expd) begin
                    $display("CHECK FAILED at %0t: read %h beat %0d data %h, expected %h",
                             $time, addr, n, rd_beat.data, expd);
                    errors++;
                end
                if (rd_beat.last != (n == int'(len))) begin
                    $display("CHECK FAILED at %0t: read %h beat %0d last flag %b",
                             $time, addr, n, rd_beat.last);
                    errors++;
                end
                n++;
                t = 0;
            end else begin
                if (t == TIMEOUT) abort_on_timeout("rd_data_ok");
                t++;
            end
        end
        if (resp != l2_axi_pkg::RESP_OKAY) exp_rd_err += int'(len) + 1;
        #2;
    endtask

    task automatic do_write(input logic [1:0] region, input logic [4:0] blk, input logic [7:0] len);
        logic [31:0] addr;
        logic [31:0] d;
        logic [31:0] s;
        logic [1:0]  resp;
        logic [7:0]  idx;
        int          t;
        addr = make_addr(region, blk);
        resp = expected_resp(region);
        wr_req = 1'b1;
        wr_req_info.addr = addr;
        wr_req_info.len  = len;
        wr_req_info.size = 3'd2;
        t = 0;
        @(posedge clk);
        while (!wr_addr_ok) begin
            if (t == TIMEOUT) abort_on_timeout("wr_addr_ok");
            t++;
            @(posedge clk);
        end
        if (aw.addr != addr || aw.len != len || aw.size != 3'd2 ||
            aw.burst != `L2_AXI_BURST_INCR || aw.id != `L2_AXI_WR_ID) begin
            $display("CHECK FAILED at %0t: AW %h for write of %h len %0d", $time, aw, addr, len);
            errors++;
        end
        #2 wr_req = 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            draw(32, d);
            draw(4, s);
            wr_beat_valid = 1'b1;
            wr_beat.data  = d;
            wr_beat.strb  = s[3:0];
            wr_beat.last  = (n == int'(len));
            t = 0;
            @(posedge clk);
            while (!wr_data_ok) begin
                if (t == TIMEOUT) abort_on_timeout("wr_data_ok");
                t++;
                @(posedge clk);
            end
            if (w.id != `L2_AXI_WR_ID) begin
                $display("CHECK FAILED at %0t: write %h beat %0d wid %h", $time, addr, n, w.id);
                errors++;
            end
            if (resp == l2_axi_pkg::RESP_OKAY) begin
                idx = addr[9:2] + 8'(n);
                for (int b = 0; b < 4; b++) begin
                    if (s[b]) shadow[idx][8*b +: 8] = d[8*b +: 8];
                end
            end
            #2;
        end
        wr_beat_valid = 1'b0;
        draw(2, s);
        repeat (s[1:0]) begin
            @(posedge clk);
            #2;
        end
        wr_resp_ready = 1'b1;
        t = 0;
        @(posedge clk);
        while (!wr_resp_valid) begin
            if (t == TIMEOUT) abort_on_timeout("wr_resp_valid");
            t++;
            @(posedge clk);
        end
        if (wr_resp != resp) begin
            $display("CHECK FAILED at %0t: write %h resp %b, expected %b",
                     $time, addr, wr_resp, resp);
            errors++;
        end
        if (resp != l2_axi_pkg::RESP_OKAY) exp_wr_err++;
        #2 wr_resp_ready = 1'b0;
    endtask

    task automatic check_counts();
        if (err_status.rd_err_cnt != 8'(exp_rd_err) || err_status.wr_err_cnt != 8'(exp_wr_err)) begin
            $display("CHECK FAILED at %0t: error counts rd %0d wr %0d, expected %0d %0d", $time,
                     err_status.rd_err_cnt, err_status.wr_err_cnt, exp_rd_err, exp_wr_err);
            errors++;
        end
        if (err_status.rd_err != (exp_rd_err != 0) || err_status.wr_err != (exp_wr_err != 0)) begin
            $display("CHECK FAILED at %0t: sticky flags rd %b wr %b", $time,
                     err_status.rd_err, err_status.wr_err);
            errors++;
        end
    endtask

    initial begin
        rstn = 1'b0;
        rd_req = 1'b0;
        rd_req_info = '0;
        wr_req = 1'b0;
        wr_req_info = '0;
        wr_beat_valid = 1'b0;
        wr_beat = '0;
        wr_resp_ready = 1'b0;
        err_clear = 1'b0;
        stall = 4'hf;
        lfsr = SEED;
        stall_lfsr = SEED;
        errors = 0;
        exp_rd_err = 0;
        exp_wr_err = 0;
        #1;
        for (int i = 0; i < 256; i++) shadow[i] = i_mem.mem[i];
        repeat (8) @(posedge clk);
        #2 rstn = 1'b1;
        @(posedge clk);
        #2;
        if (arvalid || awvalid || wvalid || rd_data_ok || wr_addr_ok || wr_resp_valid ||
            err_status != '0) begin
            $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
            errors++;
        end
        // plain reads, then write and read back
        repeat (6) begin
            draw(8, v);
            do_read(2'b00, v[4:0], {5'd0, v[7:5]});
        end
        repeat (6) begin
            draw(8, v);
            do_write(2'b00, v[4:0], {5'd0, v[7:5]});
            do_read(2'b00, v[4:0], {5'd0, v[7:5]});
        end
        check_counts();
        // error regions
        repeat (4) begin
            draw(9, v);
            do_read(v[8] ? 2'b01 : 2'b10, v[4:0], {5'd0, v[7:5]});
        end
        check_counts();
        repeat (4) begin
            draw(9, v);
            do_write(v[8] ? 2'b01 : 2'b10, v[4:0], {5'd0, v[7:5]});
        end
        check_counts();
        err_clear = 1'b1;
        @(posedge clk);
        #2 err_clear = 1'b0;
        exp_rd_err = 0;
        exp_wr_err = 0;
        if (err_status != '0) begin
            $display("CHECK FAILED at %0t: err_status %h after err_clear", $time, err_status);
            errors++;
        end
        // reads and writes together, disjoint halves of memory
        for (int i = 0; i < 6; i++) begin
            draw(7, v);
            rd_blk[i] = {1'b0, v[3:0]};
            rd_len[i] = {5'd0, v[6:4]};
            draw(7, v);
            wr_blk[i] = {1'b1, v[3:0]};
            wr_len[i] = {5'd0, v[6:4]};
        end
        fork
            for (int i = 0; i < 6; i++) do_read(2'b00, rd_blk[i], rd_len[i]);
            for (int i = 0; i < 6; i++) do_write(2'b00, wr_blk[i], wr_len[i]);
        join
        // upper half read back once both channels are quiet
        for (int i = 0; i < 6; i++) do_read(2'b00, wr_blk[i], wr_len[i]);
        check_counts();
        @(posedge clk);
        $display("test finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
